/* sources.f */
+incdir+include
hw/glb_pkg.sv
hw/glb_bank.sv
hw/glb_tile.sv
hw/glb_io_regs.sv
hw/global_buffer.sv
sim/glb_properties.sv
sim/tb_global_buffer.sv

/* Makefile */
TOP = tb_global_buffer

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^>>> PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/tb_global_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "glb_settings.svh"

module tb_global_buffer
    import glb_pkg::*;
();

    localparam int SEED          = 32'h5b1b;
    localparam int CLK_PERIOD    = 10;
    localparam int RD_LATENCY    = `GLB_NUM_TILES + 2;
    localparam int CFG_LATENCY   = 3;
    localparam int STALL_LATENCY = 3;
    localparam int NUM_COLS      = `GLB_NUM_COLS;
    localparam int TBL_MAX       = 64;
    localparam int CYC_MAX       = 2 * (TBL_MAX + 20) + 8;
    localparam int OP_IDLE       = 0;
    localparam int OP_WR         = 1;
    localparam int OP_RD         = 2;
    localparam int OP_CFG        = 3;
    localparam int OP_STALL      = 4;

    logic                     clk;
    logic                     reset;
    logic                     cgra_stall_in;
    logic                     proc_wr_en;
    glb_strb_t                proc_wr_strb;
    glb_addr_u                proc_wr_addr;
    glb_data_t                proc_wr_data;
    logic                     proc_rd_en;
    glb_addr_u                proc_rd_addr;
    glb_data_t                proc_rd_data;
    logic                     proc_rd_data_valid;
    logic                     cgra_cfg_jtag_wr_en;
    cfg_addr_t                cgra_cfg_jtag_addr;
    cfg_data_t                cgra_cfg_jtag_data;
    logic [NUM_COLS-1:0]      cgra_stall;
    logic [NUM_COLS-1:0]      cgra_cfg_g2f_wr_en;
    cfg_addr_t [NUM_COLS-1:0] cgra_cfg_g2f_addr;
    cfg_data_t [NUM_COLS-1:0] cgra_cfg_g2f_data;

    // stimulus table, one entry per cycle
    // cfg entries keep the address in the upper data half, stall entries the level in bit 0
    string     tbl_name [TBL_MAX];
    int        tbl_op   [TBL_MAX];
    glb_addr_u tbl_addr [TBL_MAX];
    glb_strb_t tbl_strb [TBL_MAX];
    glb_data_t tbl_data [TBL_MAX];
    glb_data_t tbl_exp  [TBL_MAX];
    int        tbl_len = 0;
    logic      table_ready = 1'b0;

    glb_data_t ref_mem [2 ** `GLB_ADDR_WIDTH];
    glb_data_t rd_exp_q [$];
    string     rd_name_q [$];
    int        rd_due_q [$];
    // table index of the cfg write due on a tile in a given cycle, -1 for none
    int        cfg_entry [CYC_MAX][`GLB_NUM_TILES];
    logic      stall_hist [CYC_MAX];
    int        cycle = 0;
    int        data_errors = 0;
    int        cfg_errors = 0;
    int        bit_errors = 0;
    int        other_errors = 0;

    global_buffer i_dut (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;
    always @(posedge clk) cycle <= cycle + 1;

    function automatic glb_data_t merge_bytes(input glb_data_t old_word,
                                              input glb_data_t new_word,
                                              input glb_strb_t strb);
        glb_data_t mask;
        mask = '0;
        for (int b = 0; b < `GLB_DATA_WIDTH / 8; b++) begin
            mask[b*8 +: 8] = {8{strb[b]}};
        end
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic add(input string name, input int op, input int tile, input int word,
                       input glb_strb_t strb);
        int n;
        n = tbl_len;
        tbl_name[n] = name;
        tbl_op[n] = op;
        tbl_addr[n].fields.tile_sel = glb_tile_sel_t'(tile);
        tbl_addr[n].fields.word = glb_word_addr_t'(word);
        tbl_strb[n] = strb;
        tbl_data[n] = (op == OP_STALL) ? glb_data_t'(strb[0]) : {$urandom, $urandom};
        tbl_exp[n] = tbl_data[n];
        if (op == OP_WR) begin
            ref_mem[tbl_addr[n].flat] = merge_bytes(ref_mem[tbl_addr[n].flat], tbl_data[n], strb);
        end
        if (op == OP_RD) begin
            tbl_exp[n] = ref_mem[tbl_addr[n].flat];
        end
        tbl_len++;
    endtask

    task automatic build_table();
        int tile;
        int word;
        // one full word in every tile, then back-to-back reads
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            add($sformatf("wr full t%0d", t), OP_WR, t, 5, '1);
        end
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            add($sformatf("rd full t%0d", t), OP_RD, t, 5, '0);
        end
        add("wr part t1", OP_WR, 1, 5, 8'h0f);
        add("rd part t1", OP_RD, 1, 5, '0);
        add("wr part t3", OP_WR, 3, 5, 8'hc3);
        add("rd part t3", OP_RD, 3, 5, '0);
        // same offset in the other tiles must not move
        add("wr only t2", OP_WR, 2, 5, '1);
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            add($sformatf("rd iso t%0d", t), OP_RD, t, 5, '0);
        end
        for (int k = 0; k < 6; k++) begin
            tile = $urandom_range(`GLB_NUM_TILES - 1);
            word = $urandom_range(2 ** `GLB_BANK_ADDR_WIDTH - 1);
            add($sformatf("wr rand %0d", k), OP_WR, tile, word, '1);
            add($sformatf("rd rand %0d", k), OP_RD, tile, word, '0);
        end
        add("cfg a", OP_CFG, 0, 0, '0);
        add("cfg b", OP_CFG, 0, 0, '0);
        add("idle", OP_IDLE, 0, 0, '0);
        add("cfg c", OP_CFG, 0, 0, '0);
        // a one-cycle stall pulse, then a level held for a few cycles
        add("stall pulse", OP_STALL, 0, 0, 8'h01);
        add("stall pulse end", OP_STALL, 0, 0, 8'h00);
        add("idle", OP_IDLE, 0, 0, '0);
        add("stall level", OP_STALL, 0, 0, 8'h01);
        for (int k = 0; k < 3; k++) begin
            add("idle", OP_IDLE, 0, 0, '0);
        end
        add("stall release", OP_STALL, 0, 0, 8'h00);
    endtask

    task automatic drive_idle();
        proc_wr_en = 1'b0;
        proc_rd_en = 1'b0;
        cgra_cfg_jtag_wr_en = 1'b0;
    endtask

    task automatic apply_entry(input int i);
        drive_idle();
        case (tbl_op[i])
            OP_WR: begin
                proc_wr_en   = 1'b1;
                proc_wr_addr = tbl_addr[i];
                proc_wr_strb = tbl_strb[i];
                proc_wr_data = tbl_data[i];
            end
            OP_RD: begin
                proc_rd_en   = 1'b1;
                proc_rd_addr = tbl_addr[i];
                rd_exp_q.push_back(tbl_exp[i]);
                rd_name_q.push_back(tbl_name[i]);
                rd_due_q.push_back(cycle + RD_LATENCY);
            end
            OP_CFG: begin
                cgra_cfg_jtag_wr_en = 1'b1;
                cgra_cfg_jtag_addr  = tbl_data[i][`GLB_DATA_WIDTH-1 -: `GLB_CFG_ADDR_WIDTH];
                cgra_cfg_jtag_data  = tbl_data[i][`GLB_CFG_DATA_WIDTH-1:0];
                // one register per tile on the way east
                for (int t = 0; t < `GLB_NUM_TILES; t++) begin
                    cfg_entry[cycle + CFG_LATENCY + t][t] = i;
                end
            end
            OP_STALL: begin
                cgra_stall_in = tbl_data[i][0];
            end
            default: begin
            end
        endcase
    endtask

    task automatic check_data(input string name, input glb_data_t exp, input glb_data_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            data_errors++;
        end
    endtask

    task automatic check_cfg(input string name, input cfg_addr_t exp_addr,
                             input cfg_data_t exp_data, input cfg_addr_t act_addr,
                             input cfg_data_t act_data);
        if (act_addr !== exp_addr || act_data !== exp_data) begin
            $display("ERROR %s: expected addr %h data %h, actual addr %h data %h",
                     name, exp_addr, exp_data, act_addr, act_data);
            cfg_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
            bit_errors++;
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin : monitor
        logic      due;
        logic      exp_stall;
        glb_data_t exp_word;
        string     name;
        int        due_cycle;
        int        idx;
        stall_hist[cycle] = cgra_stall_in;
        due = (rd_due_q.size() > 0) && (rd_due_q[0] == cycle);
        if (due) begin
            exp_word  = rd_exp_q.pop_front();
            name      = rd_name_q.pop_front();
            due_cycle = rd_due_q.pop_front();
            if (proc_rd_data_valid) begin
                check_data(name, exp_word, proc_rd_data);
            end else begin
                $display("read response for %s did not arrive in cycle %0d", name, due_cycle);
                other_errors++;
            end
        end else begin
            check_bit("no read due", 1'b0, proc_rd_data_valid);
        end
        exp_stall = (cycle > STALL_LATENCY) ? stall_hist[cycle - STALL_LATENCY] : 1'b0;
        for (int c = 0; c < NUM_COLS; c++) begin
            idx = cfg_entry[cycle][c / `GLB_CGRA_PER_GLB];
            check_bit($sformatf("stall col %0d", c), exp_stall, cgra_stall[c]);
            check_bit($sformatf("cfg wr_en col %0d", c), idx >= 0, cgra_cfg_g2f_wr_en[c]);
            if (idx >= 0) begin
                check_cfg($sformatf("%s col %0d", tbl_name[idx], c),
                          tbl_data[idx][`GLB_DATA_WIDTH-1 -: `GLB_CFG_ADDR_WIDTH],
                          tbl_data[idx][`GLB_CFG_DATA_WIDTH-1:0],
                          cgra_cfg_g2f_addr[c], cgra_cfg_g2f_data[c]);
            end
        end
    end

    initial begin : main
        int total;
        void'($urandom(SEED));
        reset = 1'b1;
        cgra_stall_in = 1'b0;
        proc_wr_strb = '0;
        proc_wr_addr = '0;
        proc_wr_data = '0;
        proc_rd_addr = '0;
        cgra_cfg_jtag_addr = '0;
        cgra_cfg_jtag_data = '0;
        drive_idle();
        for (int k = 0; k < CYC_MAX; k++) begin
            for (int t = 0; t < `GLB_NUM_TILES; t++) begin
                cfg_entry[k][t] = -1;
            end
        end
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < tbl_len; i++) begin
            @(posedge clk);
            #1;
            apply_entry(i);
        end
        @(posedge clk);
        #1;
        drive_idle();
        while (rd_due_q.size() > 0) begin
            @(negedge clk);
        end
        // last cfg write reaches the far tile in a known number of cycles
        repeat (CFG_LATENCY + `GLB_NUM_TILES) @(negedge clk);
        total = data_errors + cfg_errors + bit_errors + other_errors;
        $display("errors: %0d (data %0d, cfg %0d, bit %0d, other %0d)",
                 total, data_errors, cfg_errors, bit_errors, other_errors);
        if (total == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        wait (table_ready);
        #((tbl_len + 20) * CLK_PERIOD * 2);
        $display("timeout: run did not finish within %0d cycles", (tbl_len + 20) * 2);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/glb_properties.sv */
`timescale 1ns/10ps
`default_nettype none

`include "glb_settings.svh"

module glb_properties (
    input logic                     clk,
    input logic                     reset,
    input logic                     proc_rd_en,
    input logic                     proc_rd_data_valid,
    input logic                     cgra_stall_in,
    input logic [`GLB_NUM_COLS-1:0] cgra_stall,
    input logic                     cgra_cfg_jtag_wr_en,
    input logic [`GLB_NUM_COLS-1:0] cgra_cfg_g2f_wr_en
);

    // clocks seen so far, no full history for $past before the seventh
    int unsigned ticks = 0;

    always @(posedge clk) begin
        if (ticks < 8) begin
            ticks <= ticks + 1;
        end
    end

    // input register, one stage per tile, output register
    a_rd_latency: assert property (@(posedge clk) disable iff (reset || ticks < 7)
        proc_rd_data_valid == $past(proc_rd_en, `GLB_NUM_TILES + 2))
        else $error("read valid is not the read enable from six cycles earlier");

    a_stall_sync: assert property (@(posedge clk) disable iff (reset || ticks < 7)
        cgra_stall == {(`GLB_NUM_COLS){$past(cgra_stall_in, `GLB_STALL_SYNC_DEPTH)}})
        else $error("array stall does not follow the stall input by three cycles");

    a_cfg_col0: assert property (@(posedge clk) disable iff (reset || ticks < 7)
        cgra_cfg_g2f_wr_en[0] == $past(cgra_cfg_jtag_wr_en, 3))
        else $error("column 0 cfg write does not follow the jtag write by three cycles");

endmodule

bind global_buffer glb_properties i_properties (
    .clk                 (clk),
    .reset               (reset),
    .proc_rd_en          (proc_rd_en),
    .proc_rd_data_valid  (proc_rd_data_valid),
    .cgra_stall_in       (cgra_stall_in),
    .cgra_stall          (cgra_stall),
    .cgra_cfg_jtag_wr_en (cgra_cfg_jtag_wr_en),
    .cgra_cfg_g2f_wr_en  (cgra_cfg_g2f_wr_en)
);

`default_nettype wire

/* hw/global_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "glb_settings.svh"

module global_buffer
    import glb_pkg::*;
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              cgra_stall_in,

    // processor
    input  logic                              proc_wr_en,
    input  glb_strb_t                         proc_wr_strb,
    input  glb_addr_u                         proc_wr_addr,
    input  glb_data_t                         proc_wr_data,
    input  logic                              proc_rd_en,
    input  glb_addr_u                         proc_rd_addr,
    output glb_data_t                         proc_rd_data,
    output logic                              proc_rd_data_valid,

    // configuration from the global controller
    input  logic                              cgra_cfg_jtag_wr_en,
    input  cfg_addr_t                         cgra_cfg_jtag_addr,
    input  cfg_data_t                         cgra_cfg_jtag_data,

    // array columns
    output logic [`GLB_NUM_COLS-1:0]          cgra_stall,
    output logic [`GLB_NUM_COLS-1:0]          cgra_cfg_g2f_wr_en,
    output cfg_addr_t [`GLB_NUM_COLS-1:0]     cgra_cfg_g2f_addr,
    output cfg_data_t [`GLB_NUM_COLS-1:0]     cgra_cfg_g2f_data
);

    // chain nets, index i is the west side of tile i
    logic      req_wr_en   [`GLB_NUM_TILES+1];
    logic      req_rd_en   [`GLB_NUM_TILES+1];
    glb_strb_t req_wr_strb [`GLB_NUM_TILES+1];
    glb_addr_u req_addr    [`GLB_NUM_TILES+1];
    glb_data_t req_wr_data [`GLB_NUM_TILES+1];
    logic      rsp_valid   [`GLB_NUM_TILES+1];
    glb_data_t rsp_data    [`GLB_NUM_TILES+1];
    logic      cfg_wr_en   [`GLB_NUM_TILES+1];
    cfg_addr_t cfg_addr    [`GLB_NUM_TILES+1];
    cfg_data_t cfg_data    [`GLB_NUM_TILES+1];

    logic [`GLB_NUM_COLS-1:0]      col_cfg_wr_en;
    cfg_addr_t [`GLB_NUM_COLS-1:0] col_cfg_addr;
    cfg_data_t [`GLB_NUM_COLS-1:0] col_cfg_data;

    glb_io_regs i_io_regs (
        .clk                 (clk),
        .reset               (reset),
        .cgra_stall_in       (cgra_stall_in),
        .proc_wr_en          (proc_wr_en),
        .proc_wr_strb        (proc_wr_strb),
        .proc_wr_addr        (proc_wr_addr),
        .proc_wr_data        (proc_wr_data),
        .proc_rd_en          (proc_rd_en),
        .proc_rd_addr        (proc_rd_addr),
        .proc_rd_data_valid  (proc_rd_data_valid),
        .proc_rd_data        (proc_rd_data),
        .cgra_cfg_jtag_wr_en (cgra_cfg_jtag_wr_en),
        .cgra_cfg_jtag_addr  (cgra_cfg_jtag_addr),
        .cgra_cfg_jtag_data  (cgra_cfg_jtag_data),
        .tail_rsp_valid      (rsp_valid[`GLB_NUM_TILES]),
        .tail_rsp_data       (rsp_data[`GLB_NUM_TILES]),
        .col_cfg_wr_en       (col_cfg_wr_en),
        .col_cfg_addr        (col_cfg_addr),
        .col_cfg_data        (col_cfg_data),
        .req_wr_en_q         (req_wr_en[0]),
        .req_rd_en_q         (req_rd_en[0]),
        .req_wr_strb_q       (req_wr_strb[0]),
        .req_addr_q          (req_addr[0]),
        .req_wr_data_q       (req_wr_data[0]),
        .cfg_wr_en_q         (cfg_wr_en[0]),
        .cfg_addr_q          (cfg_addr[0]),
        .cfg_data_q          (cfg_data[0]),
        .cgra_stall          (cgra_stall),
        .cgra_cfg_g2f_wr_en  (cgra_cfg_g2f_wr_en),
        .cgra_cfg_g2f_addr   (cgra_cfg_g2f_addr),
        .cgra_cfg_g2f_data   (cgra_cfg_g2f_data)
    );

    // no responses enter from the west
    assign rsp_valid[0] = 1'b0;
    assign rsp_data[0]  = '0;

    for (genvar i = 0; i < `GLB_NUM_TILES; i++) begin : g_tile
        glb_tile #(
            .TILE_ID (i)
        ) i_tile (
            .clk              (clk),
            .reset            (reset),
            .req_wr_en_west   (req_wr_en[i]),
            .req_rd_en_west   (req_rd_en[i]),
            .req_wr_strb_west (req_wr_strb[i]),
            .req_addr_west    (req_addr[i]),
            .req_wr_data_west (req_wr_data[i]),
            .rsp_valid_west   (rsp_valid[i]),
            .rsp_data_west    (rsp_data[i]),
            .cfg_wr_en_west   (cfg_wr_en[i]),
            .cfg_addr_west    (cfg_addr[i]),
            .cfg_data_west    (cfg_data[i]),
            .req_wr_en_east   (req_wr_en[i+1]),
            .req_rd_en_east   (req_rd_en[i+1]),
            .req_wr_strb_east (req_wr_strb[i+1]),
            .req_addr_east    (req_addr[i+1]),
            .req_wr_data_east (req_wr_data[i+1]),
            .rsp_valid_east   (rsp_valid[i+1]),
            .rsp_data_east    (rsp_data[i+1]),
            .cfg_wr_en_east   (cfg_wr_en[i+1]),
            .cfg_addr_east    (cfg_addr[i+1]),
            .cfg_data_east    (cfg_data[i+1])
        );

        // each tile feeds the columns below it
        for (genvar c = 0; c < `GLB_CGRA_PER_GLB; c++) begin : g_col
            assign col_cfg_wr_en[i*`GLB_CGRA_PER_GLB+c] = cfg_wr_en[i+1];
            assign col_cfg_addr[i*`GLB_CGRA_PER_GLB+c]  = cfg_addr[i+1];
            assign col_cfg_data[i*`GLB_CGRA_PER_GLB+c]  = cfg_data[i+1];
        end
    end

endmodule

`default_nettype wire

/* hw/glb_io_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "glb_settings.svh"

module glb_io_regs
    import glb_pkg::*;
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              cgra_stall_in,

    // processor side
    input  logic                              proc_wr_en,
    input  glb_strb_t                         proc_wr_strb,
    input  glb_addr_u                         proc_wr_addr,
    input  glb_data_t                         proc_wr_data,
    input  logic                              proc_rd_en,
    input  glb_addr_u                         proc_rd_addr,
    output logic                              proc_rd_data_valid,
    output glb_data_t                         proc_rd_data,

    // configuration from the global controller
    input  logic                              cgra_cfg_jtag_wr_en,
    input  cfg_addr_t                         cgra_cfg_jtag_addr,
    input  cfg_data_t                         cgra_cfg_jtag_data,

    // east end of the tile chain
    input  logic                              tail_rsp_valid,
    input  glb_data_t                         tail_rsp_data,

    // per-column configuration from the tiles
    input  logic [`GLB_NUM_COLS-1:0]          col_cfg_wr_en,
    input  cfg_addr_t [`GLB_NUM_COLS-1:0]     col_cfg_addr,
    input  cfg_data_t [`GLB_NUM_COLS-1:0]     col_cfg_data,

    // into the west end of the tile chain
    output logic                              req_wr_en_q,
    output logic                              req_rd_en_q,
    output glb_strb_t                         req_wr_strb_q,
    output glb_addr_u                         req_addr_q,
    output glb_data_t                         req_wr_data_q,
    output logic                              cfg_wr_en_q,
    output cfg_addr_t                         cfg_addr_q,
    output cfg_data_t                         cfg_data_q,

    // toward the array
    output logic [`GLB_NUM_COLS-1:0]          cgra_stall,
    output logic [`GLB_NUM_COLS-1:0]          cgra_cfg_g2f_wr_en,
    output cfg_addr_t [`GLB_NUM_COLS-1:0]     cgra_cfg_g2f_addr,
    output cfg_data_t [`GLB_NUM_COLS-1:0]     cgra_cfg_g2f_data
);

    logic [`GLB_STALL_SYNC_DEPTH-1:0] stall_sync;

    // input side, one address carries both reads and writes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req_wr_en_q   <= 1'b0;
            req_rd_en_q   <= 1'b0;
            req_wr_strb_q <= '0;
            req_addr_q    <= '0;
            req_wr_data_q <= '0;
            cfg_wr_en_q   <= 1'b0;
            cfg_addr_q    <= '0;
            cfg_data_q    <= '0;
        end else begin
            req_wr_en_q   <= proc_wr_en;
            req_rd_en_q   <= proc_rd_en;
            req_wr_strb_q <= proc_wr_strb;
            req_addr_q    <= proc_rd_en ? proc_rd_addr : proc_wr_addr;
            req_wr_data_q <= proc_wr_data;
            cfg_wr_en_q   <= cgra_cfg_jtag_wr_en;
            cfg_addr_q    <= cgra_cfg_jtag_addr;
            cfg_data_q    <= cgra_cfg_jtag_data;
        end
    end

    // output side
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            proc_rd_data_valid <= 1'b0;
            proc_rd_data       <= '0;
            cgra_cfg_g2f_wr_en <= '0;
            cgra_cfg_g2f_addr  <= '0;
            cgra_cfg_g2f_data  <= '0;
        end else begin
            proc_rd_data_valid <= tail_rsp_valid;
            proc_rd_data       <= tail_rsp_data;
            cgra_cfg_g2f_wr_en <= col_cfg_wr_en;
            cgra_cfg_g2f_addr  <= col_cfg_addr;
            cgra_cfg_g2f_data  <= col_cfg_data;
        end
    end

    // stall synchronizer, last stage drives every column
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stall_sync <= '0;
        end else begin
            stall_sync <= {stall_sync[`GLB_STALL_SYNC_DEPTH-2:0], cgra_stall_in};
        end
    end

    assign cgra_stall = {(`GLB_NUM_COLS){stall_sync[`GLB_STALL_SYNC_DEPTH-1]}};

endmodule

`default_nettype wire

/* hw/glb_tile.sv */
`timescale 1ns/10ps
`default_nettype none

`include "glb_settings.svh"

module glb_tile
    import glb_pkg::*;
#(
    parameter int TILE_ID = 0
) (
    input  logic      clk,
    input  logic      reset,

    // processor request from the west
    input  logic      req_wr_en_west,
    input  logic      req_rd_en_west,
    input  glb_strb_t req_wr_strb_west,
    input  glb_addr_u req_addr_west,
    input  glb_data_t req_wr_data_west,

    // read response from the west
    input  logic      rsp_valid_west,
    input  glb_data_t rsp_data_west,

    // configuration from the west
    input  logic      cfg_wr_en_west,
    input  cfg_addr_t cfg_addr_west,
    input  cfg_data_t cfg_data_west,

    // same bundles toward the east
    output logic      req_wr_en_east,
    output logic      req_rd_en_east,
    output glb_strb_t req_wr_strb_east,
    output glb_addr_u req_addr_east,
    output glb_data_t req_wr_data_east,
    output logic      rsp_valid_east,
    output glb_data_t rsp_data_east,
    output logic      cfg_wr_en_east,
    output cfg_addr_t cfg_addr_east,
    output cfg_data_t cfg_data_east
);

    logic      tile_hit;
    logic      rd_hit_q;
    logic      rsp_valid_q;
    glb_data_t rsp_data_q;
    glb_data_t bank_rd_data;

    // this tile owns the access when the select field matches
    assign tile_hit = (req_addr_west.fields.tile_sel == glb_tile_sel_t'(TILE_ID));

    glb_bank i_bank (
        .clk     (clk),
        .wr_en   (req_wr_en_west & tile_hit),
        .wr_strb (req_wr_strb_west),
        .wr_addr (req_addr_west.fields.word),
        .wr_data (req_wr_data_west),
        .rd_en   (req_rd_en_west & tile_hit),
        .rd_addr (req_addr_west.fields.word),
        .rd_data (bank_rd_data)
    );

    // request, response and configuration stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req_wr_en_east   <= 1'b0;
            req_rd_en_east   <= 1'b0;
            req_wr_strb_east <= '0;
            req_addr_east    <= '0;
            req_wr_data_east <= '0;
            rd_hit_q         <= 1'b0;
            rsp_valid_q      <= 1'b0;
            rsp_data_q       <= '0;
            cfg_wr_en_east   <= 1'b0;
            cfg_addr_east    <= '0;
            cfg_data_east    <= '0;
        end else begin
            req_wr_en_east   <= req_wr_en_west;
            req_rd_en_east   <= req_rd_en_west;
            req_wr_strb_east <= req_wr_strb_west;
            req_addr_east    <= req_addr_west;
            req_wr_data_east <= req_wr_data_west;
            rd_hit_q         <= req_rd_en_west & tile_hit;
            rsp_valid_q      <= rsp_valid_west;
            rsp_data_q       <= rsp_data_west;
            cfg_wr_en_east   <= cfg_wr_en_west;
            cfg_addr_east    <= cfg_addr_west;
            cfg_data_east    <= cfg_data_west;
        end
    end

    // bank data joins the response beside its own request
    // a read matches only one tile, so the west slot is empty on a hit
    assign rsp_valid_east = rd_hit_q | rsp_valid_q;
    assign rsp_data_east  = rd_hit_q ? bank_rd_data : rsp_data_q;

endmodule

`default_nettype wire

/* hw/glb_bank.sv */
`timescale 1ns/10ps
`default_nettype none

`include "glb_settings.svh"

module glb_bank
    import glb_pkg::*;
(
    input  logic           clk,

    // write port with byte strobes
    input  logic           wr_en,
    input  glb_strb_t      wr_strb,
    input  glb_word_addr_t wr_addr,
    input  glb_data_t      wr_data,

    // registered read port
    input  logic           rd_en,
    input  glb_word_addr_t rd_addr,
    output glb_data_t      rd_data
);

    localparam int NUM_WORDS = 2 ** `GLB_BANK_ADDR_WIDTH;
    localparam int NUM_BYTES = `GLB_DATA_WIDTH / 8;

    glb_data_t mem [NUM_WORDS];

    // byte-wise update, untouched bytes keep their value
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

    // read-first: nonblocking update lands after this sample
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* hw/glb_pkg.sv */
`default_nettype none

`include "glb_settings.svh"

package glb_pkg;

    // processor data and byte strobes
    typedef logic [`GLB_DATA_WIDTH-1:0] glb_data_t;
    typedef logic [`GLB_DATA_WIDTH/8-1:0] glb_strb_t;

    // address pieces
    typedef logic [`GLB_BANK_ADDR_WIDTH-1:0] glb_word_addr_t;
    typedef logic [`GLB_TILE_SEL_WIDTH-1:0] glb_tile_sel_t;

    typedef struct packed {
        glb_tile_sel_t  tile_sel;
        glb_word_addr_t word;
    } glb_addr_fields_s;

    // flat view on the boundary, field view inside the tiles
    typedef union packed {
        logic [`GLB_ADDR_WIDTH-1:0] flat;
        glb_addr_fields_s           fields;
    } glb_addr_u;

    // configuration write to the array
    typedef logic [`GLB_CFG_ADDR_WIDTH-1:0] cfg_addr_t;
    typedef logic [`GLB_CFG_DATA_WIDTH-1:0] cfg_data_t;

endpackage

`default_nettype wire

/* include/glb_settings.svh */
`ifndef GLB_SETTINGS_SVH
`define GLB_SETTINGS_SVH

// tile chain geometry
`define GLB_NUM_TILES 4
`define GLB_CGRA_PER_GLB 2
`define GLB_NUM_COLS (`GLB_NUM_TILES * `GLB_CGRA_PER_GLB)

// processor address split, tile select on top
`define GLB_TILE_SEL_WIDTH 2
`define GLB_BANK_ADDR_WIDTH 6
`define GLB_ADDR_WIDTH (`GLB_TILE_SEL_WIDTH + `GLB_BANK_ADDR_WIDTH)

// processor word
`define GLB_DATA_WIDTH 64

// configuration bus to the array
`define GLB_CFG_ADDR_WIDTH 32
`define GLB_CFG_DATA_WIDTH 32

// array stall synchronizer
`define GLB_STALL_SYNC_DEPTH 3

`endif
